// ==== Bender.yml ====
package:
  name: write_delayer

sources:
  - include_dirs:
      - common
    files:
      - common/delay_pkg.sv
      - common/delay_lane_if.sv
      - hw/delayer/write_dispatch.sv
      - hw/delayer/delay_lane.sv
      - hw/delayer/write_collect.sv
      - hw/write_delayer_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/tb_write_delayer.sv

// ==== common/delay_cfg.svh ====
// Widths, lane count and LFSR seed of the write delayer, included by its package and RTL modules
`ifndef DELAY_CFG_SVH
`define DELAY_CFG_SVH

// Address carried by one write request
`define DELAY_ADDR_WIDTH 32

// Data word carried alongside the address, like a single W beat
`define DELAY_DATA_WIDTH 32

// Transaction ID shared by the request and its B response
`define DELAY_ID_WIDTH 8

// Number of delay lanes, i.e. how many requests may be in flight at once
`define DELAY_NUM_LANES 4

// Stall counts span 0 to 15 cycles with four bits
`define DELAY_STALL_WIDTH 4

// Reset value of the random stall generator, must never be zero
`define DELAY_LFSR_SEED 16'hace1

`endif

// ==== common/delay_lane_if.sv ====
// Valid/ready link that carries one write request and its stall count into or out of a lane
`timescale 1ns/100ps
`default_nettype none

interface delay_lane_if import delay_pkg::*; ();

  // Handshake pair, a transfer happens on an edge where both are high
  logic   valid;
  logic   ready;

  // Request payload, stable while valid waits for ready
  addr_t  addr;
  data_t  data;
  id_t    id;

  // Stall count on the feed side; on the drain side the lane reports its remaining count
  stall_t stall;

  // Dispatcher side of a feed link
  modport feed (
    output valid,
    output addr,
    output data,
    output id,
    output stall,
    input  ready
  );

  // Lane side of a feed link
  modport lane_in (
    input  valid,
    input  addr,
    input  data,
    input  id,
    input  stall,
    output ready
  );

  // Lane side of a drain link
  modport lane_out (
    output valid,
    output addr,
    output data,
    output id,
    output stall,
    input  ready
  );

  // Collector side of a drain link, the stall count is of no interest there
  modport drain (
    input  valid,
    input  addr,
    input  data,
    input  id,
    output ready
  );

endinterface

`default_nettype wire

// ==== common/delay_pkg.sv ====
// Shared types of the write delayer, imported by wildcard in every RTL module header
`default_nettype none

`include "delay_cfg.svh"

package delay_pkg;

  // Payload fields of a write request
  typedef logic [`DELAY_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DELAY_DATA_WIDTH-1:0] data_t;
  typedef logic [`DELAY_ID_WIDTH-1:0]   id_t;

  // Number of cycles a request is held back inside its lane
  typedef logic [`DELAY_STALL_WIDTH-1:0] stall_t;

  // Index of one delay lane, used by both round-robin pointers
  typedef logic [$clog2(`DELAY_NUM_LANES)-1:0] lane_idx_t;

  // Lane FSM
  // IDLE waits for a request, WAIT counts the stall down, OFFER presents it downstream
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    WAIT  = 2'd1,
    OFFER = 2'd2
  } lane_state_e;

  // Source of the stall count, selected at run time
  typedef enum logic {
    STALL_FIXED  = 1'b0,
    STALL_RANDOM = 1'b1
  } stall_mode_e;

endpackage

`default_nettype wire

// ==== hw/delayer/delay_lane.sv ====
// One delay lane: holds a single request, counts its stall down, then offers it to the collector
`timescale 1ns/100ps
`default_nettype none

module delay_lane import delay_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  delay_lane_if.lane_in  in_req,
  delay_lane_if.lane_out out_req
);

  lane_state_e state_q;

  // Remaining stall cycles, zero once the request is on offer
  stall_t count_q;

  // Held payload, written only when a request enters the lane
  addr_t addr_q;
  data_t data_q;
  id_t   id_q;

  logic in_xfer;
  logic out_xfer;

  // The lane holds one request, so it only listens while empty
  assign in_req.ready = (state_q == IDLE);
  assign in_xfer      = in_req.valid && in_req.ready;

  assign out_req.valid = (state_q == OFFER);
  assign out_req.addr  = addr_q;
  assign out_req.data  = data_q;
  assign out_req.id    = id_q;
  assign out_req.stall = count_q;
  assign out_xfer      = out_req.valid && out_req.ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (in_xfer) begin
            count_q <= in_req.stall;
            // A zero stall skips the wait entirely
            state_q <= (in_req.stall == '0) ? OFFER : WAIT;
          end
        end
        WAIT: begin
          // Exactly stall cycles are spent here
          count_q <= count_q - stall_t'(1);
          if (count_q == stall_t'(1)) begin
            state_q <= OFFER;
          end
        end
        OFFER: begin
          if (out_xfer) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      addr_q <= in_req.addr;
      data_q <= in_req.data;
      id_q   <= in_req.id;
    end
  end

  // A stalled offer keeps its request until the collector takes it
  assert property (@(posedge clk) disable iff (!rst_n)
    out_req.valid && !out_req.ready |=>
      out_req.valid && $stable(addr_q) && $stable(data_q) && $stable(id_q));

  // A held request keeps the lane closed to new input until the collector drains it
  assert property (@(posedge clk) disable iff (!rst_n)
    !in_req.ready && !out_xfer |=> !in_req.ready);

endmodule

`default_nettype wire

// ==== hw/delayer/write_collect.sv ====
// Drains the delay lanes in round-robin order into the master-side output register
`timescale 1ns/100ps
`default_nettype none

`include "delay_cfg.svh"

module write_collect import delay_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  delay_lane_if.drain lanes [`DELAY_NUM_LANES],
  output logic        mst_valid,
  input  logic        mst_ready,
  output addr_t       mst_addr,
  output data_t       mst_data,
  output id_t         mst_id
);

  // Lane that must be drained next, follows the dispatcher's order
  lane_idx_t ptr_q;

  // Lane outputs gathered into arrays for selection by the pointer
  logic [`DELAY_NUM_LANES-1:0] lane_valid;
  addr_t                       lane_addr [`DELAY_NUM_LANES];
  data_t                       lane_data [`DELAY_NUM_LANES];
  id_t                         lane_id   [`DELAY_NUM_LANES];

  // The output register can take a new entry this cycle
  logic load_ok;
  logic take;

  // Empty, or its current entry leaves on this edge
  assign load_ok = !mst_valid || mst_ready;
  assign take    = load_ok && lane_valid[ptr_q];

  for (genvar g = 0; g < `DELAY_NUM_LANES; g++) begin : gen_drain
    assign lane_valid[g]  = lanes[g].valid;
    assign lane_addr[g]   = lanes[g].addr;
    assign lane_data[g]   = lanes[g].data;
    assign lane_id[g]     = lanes[g].id;
    // Only the pointed lane is ever told it was drained
    assign lanes[g].ready = load_ok && (ptr_q == lane_idx_t'(g));
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q     <= '0;
      mst_valid <= 1'b0;
    end else begin
      if (take) begin
        mst_valid <= 1'b1;
        if (ptr_q == lane_idx_t'(`DELAY_NUM_LANES - 1)) begin
          ptr_q <= '0;
        end else begin
          ptr_q <= ptr_q + lane_idx_t'(1);
        end
      end else if (mst_ready) begin
        mst_valid <= 1'b0;
      end
    end
  end

  // Payload register, loaded together with the drain transfer
  always_ff @(posedge clk) begin
    if (take) begin
      mst_addr <= lane_addr[ptr_q];
      mst_data <= lane_data[ptr_q];
      mst_id   <= lane_id[ptr_q];
    end
  end

  // A stalled master-side beat must not change or disappear
  assert property (@(posedge clk) disable iff (!rst_n)
    mst_valid && !mst_ready |=>
      mst_valid && $stable(mst_addr) && $stable(mst_data) && $stable(mst_id));

endmodule

`default_nettype wire

// ==== hw/delayer/write_dispatch.sv ====
// Accepts slave-side write requests, draws a stall count and steers each one to the next lane
`timescale 1ns/100ps
`default_nettype none

`include "delay_cfg.svh"

module write_dispatch import delay_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        slv_valid,
  output logic        slv_ready,
  input  addr_t       slv_addr,
  input  data_t       slv_data,
  input  id_t         slv_id,
  input  stall_mode_e stall_mode,
  input  stall_t      fixed_delay,
  delay_lane_if.feed  lanes [`DELAY_NUM_LANES]
);

  // Round-robin pointer to the lane that takes the next request
  lane_idx_t ptr_q;

  // Fibonacci LFSR that supplies the random stall counts
  logic [15:0] lfsr_q;
  logic        lfsr_fb;

  // Goes high one cycle after reset so no request is taken while leaving reset
  logic accept_en_q;

  // Ready of every lane, gathered so the pointer can select one of them
  logic [`DELAY_NUM_LANES-1:0] lane_ready;

  // Stall count handed to the lane together with the current request
  stall_t stall;

  logic accept;

  // Taps 16, 14, 13 and 11 give a maximal length sequence
  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  // In random mode the low LFSR bits form the stall
  assign stall = (stall_mode == STALL_RANDOM) ? stall_t'(lfsr_q[`DELAY_STALL_WIDTH-1:0])
                                              : fixed_delay;

  // A busy target lane holds the slave side back even if other lanes are free,
  // which keeps the round-robin order intact
  assign slv_ready = accept_en_q && lane_ready[ptr_q];
  assign accept    = slv_valid && slv_ready;

  // Only the pointed lane sees valid, all lanes share the payload wires
  for (genvar g = 0; g < `DELAY_NUM_LANES; g++) begin : gen_feed
    assign lanes[g].valid = slv_valid && accept_en_q && (ptr_q == lane_idx_t'(g));
    assign lanes[g].addr  = slv_addr;
    assign lanes[g].data  = slv_data;
    assign lanes[g].id    = slv_id;
    assign lanes[g].stall = stall;
    assign lane_ready[g]  = lanes[g].ready;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      accept_en_q <= 1'b0;
    end else begin
      accept_en_q <= 1'b1;
    end
  end

  // Pointer moves on after every accepted request and wraps at the last lane
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (accept) begin
      if (ptr_q == lane_idx_t'(`DELAY_NUM_LANES - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= ptr_q + lane_idx_t'(1);
      end
    end
  end

  // The LFSR steps once per accepted request, whatever the mode, so the
  // random sequence only depends on the number of requests seen
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lfsr_q <= `DELAY_LFSR_SEED;
    end else if (accept) begin
      lfsr_q <= {lfsr_q[14:0], lfsr_fb};
    end
  end

endmodule

`default_nettype wire

// ==== hw/write_delayer_top.sv ====
// Top level of the write delayer: dispatcher, delay lanes and collector, with B passed straight back
`timescale 1ns/100ps
`default_nettype none

`include "delay_cfg.svh"

module write_delayer_top import delay_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // Slave side, requests come in here
  input  logic        slv_valid,
  output logic        slv_ready,
  input  addr_t       slv_addr,
  input  data_t       slv_data,
  input  id_t         slv_id,

  // Master side, delayed requests leave here in arrival order
  output logic        mst_valid,
  input  logic        mst_ready,
  output addr_t       mst_addr,
  output data_t       mst_data,
  output id_t         mst_id,

  // Write response from the memory
  input  logic        mst_b_valid,
  output logic        mst_b_ready,
  input  id_t         mst_b_id,

  // Write response towards the requester
  output logic        slv_b_valid,
  input  logic        slv_b_ready,
  output id_t         slv_b_id,

  // Stall configuration, taken when a request is accepted
  input  stall_mode_e stall_mode,
  input  stall_t      fixed_delay
);

  // One feed and one drain link per lane
  delay_lane_if feed_if  [`DELAY_NUM_LANES] ();
  delay_lane_if drain_if [`DELAY_NUM_LANES] ();

  write_dispatch i_dispatch (
    .clk         (clk),
    .rst_n       (rst_n),
    .slv_valid   (slv_valid),
    .slv_ready   (slv_ready),
    .slv_addr    (slv_addr),
    .slv_data    (slv_data),
    .slv_id      (slv_id),
    .stall_mode  (stall_mode),
    .fixed_delay (fixed_delay),
    .lanes       (feed_if)
  );

  for (genvar g = 0; g < `DELAY_NUM_LANES; g++) begin : gen_lane
    delay_lane i_lane (
      .clk     (clk),
      .rst_n   (rst_n),
      .in_req  (feed_if[g]),
      .out_req (drain_if[g])
    );
  end

  write_collect i_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .lanes     (drain_if),
    .mst_valid (mst_valid),
    .mst_ready (mst_ready),
    .mst_addr  (mst_addr),
    .mst_data  (mst_data),
    .mst_id    (mst_id)
  );

  // B is not delayed, it goes through wire for wire
  assign slv_b_valid = mst_b_valid;
  assign slv_b_id    = mst_b_id;
  assign mst_b_ready = slv_b_ready;

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/delay_pkg.sv
common/delay_lane_if.sv
hw/delayer/write_dispatch.sv
hw/delayer/delay_lane.sv
hw/delayer/write_collect.sv
hw/write_delayer_top.sv
test/tb_write_delayer.sv

// ==== test/tb_write_delayer.sv ====
// Self-checking testbench for write_delayer_top, run from the project root so the cases file is found
`timescale 1ns/100ps
`default_nettype none

`include "delay_cfg.svh"

module tb_write_delayer import delay_pkg::*; ();

  // Latency column markers, any value from zero up is an exact latency
  localparam int LAT_NONE = -1;
  localparam int LAT_HOLD = -2;
  // Stalled cycles after which a held DUT must be completely full
  localparam int HOLD_WAIT = 24;
  // Behaviour of the model slave on mst_ready
  localparam int RDY_RANDOM = 0;
  localparam int RDY_HIGH   = 1;
  localparam int RDY_LOW    = 2;

  logic        clk         = 1'b0;
  logic        rst_n       = 1'b0;
  logic        slv_valid   = 1'b0;
  logic        slv_ready;
  addr_t       slv_addr    = '0;
  data_t       slv_data    = '0;
  id_t         slv_id      = '0;
  logic        mst_valid;
  logic        mst_ready   = 1'b0;
  addr_t       mst_addr;
  data_t       mst_data;
  id_t         mst_id;
  logic        mst_b_valid = 1'b0;
  logic        mst_b_ready;
  id_t         mst_b_id    = '0;
  logic        slv_b_valid;
  logic        slv_b_ready = 1'b0;
  id_t         slv_b_id;
  stall_mode_e stall_mode  = STALL_FIXED;
  stall_t      fixed_delay = '0;

  // Cases as read from the file, one entry per request
  string  case_name[$];
  bit     case_random[$];
  stall_t case_delay[$];
  addr_t  case_addr[$];
  data_t  case_data[$];
  id_t    case_id[$];
  int     case_lat[$];

  // Requests accepted on the slave side and not yet seen on the master side
  string exp_name[$];
  addr_t exp_addr[$];
  data_t exp_data[$];
  id_t   exp_id[$];
  int    exp_lat[$];
  int    exp_acc[$];

  // Responses the model slave still owes, oldest first
  id_t   b_ids[$];
  string b_names[$];

  int          cycle         = 0;
  int          timeout_limit = 1000000;
  int          n_accepted    = 0;
  int          n_done        = 0;
  int          n_b           = 0;
  int          ready_mode    = RDY_RANDOM;
  bit          hold_released = 1'b0;
  logic [31:0] lfsr          = 32'h176f_5fba;
  // Master-side beat tracking for the latency and stability checks
  bit          beat_new      = 1'b1;
  int          beat_start    = 0;
  bit          held          = 1'b0;
  addr_t       held_addr;
  data_t       held_data;
  id_t         held_id;

  // Port names match the testbench signals one to one
  write_delayer_top dut (.*);

  always #5 clk = ~clk;

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic end_with_failure();
    $display("TEST FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_addr(input string test, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: addr expected %h, got %h", test, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_data(input string test, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: data expected %h, got %h", test, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_id(input string test, input id_t exp, input id_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: id expected %h, got %h", test, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_latency(input string test, input int exp, input int act);
    if (act != exp) begin
      $display("[ERROR] %s: latency expected %0d, got %0d", test, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_count(input string test, input int exp, input int act);
    if (act != exp) begin
      $display("[ERROR] %s: requests in flight expected %0d, got %0d", test, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_flag(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: flag expected %b, got %b", test, exp, act);
      end_with_failure();
    end
  endtask

  task automatic load_cases();
    int     fd;
    int     r;
    int     dly;
    string  tok;
    string  mode_s;
    string  lat_s;
    string  rest;
    addr_t  a;
    data_t  d;
    id_t    id;
    fd = $fopen("test/write_delayer_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open test/write_delayer_cases.txt");
      end_with_failure();
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        // Lines starting with a hash only describe the columns
        if (tok.substr(0, 0) == "#") begin
          r = $fgets(rest, fd);
        end else begin
          r = $fscanf(fd, "%s %d %h %h %h %s", mode_s, dly, a, d, id, lat_s);
          if (r != 6) begin
            $display("Malformed line in the cases file at test %s", tok);
            end_with_failure();
          end else begin
            case_name.push_back(tok);
            case_random.push_back(mode_s == "random");
            case_delay.push_back(stall_t'(dly));
            case_addr.push_back(a);
            case_data.push_back(d);
            case_id.push_back(id);
            if (lat_s == "none") begin
              case_lat.push_back(LAT_NONE);
            end else if (lat_s == "hold") begin
              case_lat.push_back(LAT_HOLD);
            end else begin
              case_lat.push_back(lat_s.atoi());
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Offers one request on the slave side and waits for its acceptance
  task automatic send_case(input int i);
    int stalled;
    bit taken;
    stalled = 0;
    taken   = 1'b0;
    @(negedge clk);
    if (case_lat[i] >= 0) begin
      // A timed request needs an empty DUT and an always ready master side
      while (exp_addr.size() != 0) begin
        @(negedge clk);
      end
      ready_mode    = RDY_HIGH;
      hold_released = 1'b0;
      @(negedge clk);
    end else if (case_lat[i] == LAT_HOLD) begin
      if (!hold_released) begin
        ready_mode = RDY_LOW;
      end
    end else begin
      ready_mode    = RDY_RANDOM;
      hold_released = 1'b0;
    end
    @(posedge clk);
    slv_valid   <= 1'b1;
    slv_addr    <= case_addr[i];
    slv_data    <= case_data[i];
    slv_id      <= case_id[i];
    fixed_delay <= case_delay[i];
    stall_mode  <= case_random[i] ? STALL_RANDOM : STALL_FIXED;
    while (!taken) begin
      @(posedge clk);
      if (slv_ready) begin
        taken = 1'b1;
        exp_name.push_back(case_name[i]);
        exp_addr.push_back(case_addr[i]);
        exp_data.push_back(case_data[i]);
        exp_id.push_back(case_id[i]);
        exp_lat.push_back(case_lat[i] >= 0 ? case_lat[i] : LAT_NONE);
        exp_acc.push_back(cycle);
        n_accepted++;
      end else begin
        stalled++;
        if (case_lat[i] == LAT_HOLD && !hold_released && stalled == HOLD_WAIT) begin
          // Every lane and the output register are occupied by now
          check_count(case_name[i], `DELAY_NUM_LANES + 1, exp_addr.size());
          @(negedge clk);
          ready_mode    = RDY_RANDOM;
          hold_released = 1'b1;
        end
      end
    end
    slv_valid <= 1'b0;
  endtask

  // Master-side monitor and model slave, including the B responder
  always @(posedge clk) begin : respond
    string nm;
    int    lat;
    int    acc;
    id_t   id;
    logic  b_done;
    if (!rst_n) begin
      mst_ready   <= 1'b0;
      mst_b_valid <= 1'b0;
      slv_b_ready <= 1'b0;
    end else begin
      // Nothing may leave before the first request has been taken
      if (n_accepted == 0) begin
        check_flag("idle_after_reset", 1'b0, mst_valid);
      end
      // A beat stalled on the previous edge must still be there, unchanged
      if (held) begin
        check_flag("held_valid", 1'b1, mst_valid);
        check_addr("held_beat", held_addr, mst_addr);
        check_data("held_beat", held_data, mst_data);
        check_id("held_beat", held_id, mst_id);
      end
      held      = mst_valid && !mst_ready;
      held_addr = mst_addr;
      held_data = mst_data;
      held_id   = mst_id;
      if (mst_valid && beat_new) begin
        beat_start = cycle;
        beat_new   = 1'b0;
      end
      if (mst_valid && mst_ready) begin
        if (exp_addr.size() == 0) begin
          $display("A master-side beat arrived with no request outstanding");
          end_with_failure();
        end else begin
          nm  = exp_name.pop_front();
          id  = exp_id.pop_front();
          lat = exp_lat.pop_front();
          acc = exp_acc.pop_front();
          check_addr(nm, exp_addr.pop_front(), mst_addr);
          check_data(nm, exp_data.pop_front(), mst_data);
          check_id(nm, id, mst_id);
          if (lat >= 0) begin
            check_latency(nm, lat, beat_start - acc);
          end
          b_ids.push_back(id);
          b_names.push_back(nm);
          beat_new = 1'b1;
          n_done++;
        end
      end
      // B goes straight through, so each side mirrors the other
      check_flag("b_valid_pass", mst_b_valid, slv_b_valid);
      check_flag("b_ready_pass", slv_b_ready, mst_b_ready);
      b_done = mst_b_valid && mst_b_ready;
      if (b_done) begin
        check_id(b_names.pop_front(), b_ids.pop_front(), slv_b_id);
        n_b++;
      end
      if (!mst_b_valid || b_done) begin
        lfsr = lfsr_step(lfsr);
        if (b_ids.size() != 0 && lfsr[0]) begin
          mst_b_valid <= 1'b1;
          mst_b_id    <= b_ids[0];
        end else begin
          mst_b_valid <= 1'b0;
        end
      end
      lfsr = lfsr_step(lfsr);
      slv_b_ready <= lfsr[0];
      case (ready_mode)
        RDY_HIGH: mst_ready <= 1'b1;
        RDY_LOW:  mst_ready <= 1'b0;
        default: begin
          lfsr = lfsr_step(lfsr);
          mst_ready <= lfsr[0];
        end
      endcase
    end
  end

  // Cycle counter, also bounds the run against a deadlock
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle > timeout_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycle);
      end_with_failure();
    end
  end

  initial begin
    load_cases();
    timeout_limit = case_name.size() * 40;
    repeat (5) @(posedge clk);
    check_flag("reset_slv_ready", 1'b0, slv_ready);
    check_flag("reset_mst_valid", 1'b0, mst_valid);
    rst_n <= 1'b1;
    foreach (case_name[i]) begin
      send_case(i);
    end
    while (n_done < case_name.size() || n_b < case_name.size()) begin
      @(negedge clk);
    end
    // Leave room for a stray duplicate beat to show up
    repeat (20) @(negedge clk);
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/write_delayer_cases.txt ====
# name mode fixed_delay(dec) addr(hex) data(hex) id(hex) latency
# latency: cycles from accept to mst_valid, none = untimed, hold = sent with mst_ready held low
lat_zero   fixed  0  00001000 a5a5a5a5 01 2
lat_three  fixed  3  00001004 5a5a5a5a 02 5
lat_max    fixed  15 00001008 deadbeef 03 17
rnd_order  random 0  00002000 00000011 10 none
rnd_order  random 0  00002004 00000022 11 none
rnd_order  random 0  00002008 00000033 12 none
rnd_order  random 0  0000200c 00000044 13 none
rnd_order  random 0  00002010 00000055 14 none
rnd_order  random 0  00002014 00000066 15 none
fix_gap    fixed  7  00003000 12345678 20 none
fix_gap    fixed  1  00003004 87654321 21 none
bp_fill    random 0  00004000 c0de0001 30 hold
bp_fill    random 0  00004004 c0de0002 31 hold
bp_fill    random 0  00004008 c0de0003 32 hold
bp_fill    random 0  0000400c c0de0004 33 hold
bp_fill    random 0  00004010 c0de0005 34 hold
bp_fill    random 0  00004014 c0de0006 35 hold
bp_fill    random 0  00004018 c0de0007 36 hold
lat_after  fixed  3  00005000 0badf00d 40 5
